// ==== design/mmio_cmd_pkg.sv ====
package mmio_cmd_pkg;

  // Command field widths
  localparam int ADR_W = 28;
  localparam int LUN_W = 4;
  localparam int TAG_W = 4;
  localparam int LEN_W = 16;

  // One command per frame, always this many bytes
  localparam int CMD_BYTES = 11;

  // Index of the final byte of each field within the frame
  localparam int MAGIC_LAST = 3;
  localparam int ADDR_LAST = 7;
  localparam int WORD_LAST = 9;

  // Bit positions inside the tag/op byte
  localparam int DIR_BIT = 3;
  localparam int APB_BIT = 2;

  // 'T','A','R','T' as collected little-endian, first byte in bits 7..0
  localparam logic [31:0] MMIO_MAGIC = 32'h5452_4154;

  // Opcodes, STORE is the only one with a Bulk-Out data phase
  typedef enum logic [1:0] {
    OP_STORE = 2'd0,
    OP_FETCH = 2'd1,
    OP_SET   = 2'd2,
    OP_GET   = 2'd3
  } mmio_op_e;

  // Parser walks magic, address, length/value, tag/op
  typedef enum logic [2:0] {
    PS_MAGIC,
    PS_ADDR,
    PS_WORD,
    PS_IDOP,
    PS_BUSY,
    PS_FAIL
  } parse_state_e;

endpackage

// ==== design/usb_ep_pkg.sv ====
package usb_ep_pkg;

  // High-level phases of the Bulk-Out endpoint
  typedef enum logic [1:0] {
    // Waiting for a command frame
    EP_IDLE,
    // Data phase, or back end busy with the command
    EP_XFER,
    // Waiting for the response to go out
    EP_RESP,
    // Stalled until the configuration changes
    EP_HALT
  } ep_state_e;

  // High-speed bulk packet size
  localparam int DEF_MAX_PACKET = 512;

  // Room for a few packets of STORE data
  localparam int DEF_FIFO_DEPTH = 2048;

endpackage

// ==== design/mmio_cmd_parser.sv ====
module mmio_cmd_parser (
  input  logic                             clock,
  input  logic                             rst_n_i,
  input  logic                             clear_i,
  input  logic                             restart_i,
  input  logic                             byte_valid_i,
  output logic                             byte_ready_o,
  input  logic                             byte_keep_i,
  input  logic                             byte_last_i,
  input  logic [7:0]                       byte_data_i,
  output logic                             cmd_vld_o,
  input  logic                             cmd_ready_i,
  output mmio_cmd_pkg::mmio_op_e           cmd_op_o,
  output logic                             cmd_dir_o,
  output logic                             cmd_apb_o,
  output logic [mmio_cmd_pkg::TAG_W-1:0]   cmd_tag_o,
  output logic [mmio_cmd_pkg::LEN_W-1:0]   cmd_len_o,
  output logic [mmio_cmd_pkg::LUN_W-1:0]   cmd_lun_o,
  output logic [mmio_cmd_pkg::ADR_W-1:0]   cmd_adr_o,
  output logic                             cmd_done_o,
  output logic                             cmd_bad_o
);
  import mmio_cmd_pkg::*;

  parse_state_e state_q;
  logic [31:0]  word_q;
  logic [31:0]  word_next;
  logic [3:0]   idx_q;
  logic         accept;
  logic         beat_bad;
  logic         cmd_ok;

  assign accept = byte_valid_i && byte_ready_o;

  // Little-endian collection, newest byte lands in the top
  assign word_next = {byte_data_i, word_q[31:8]};

  // Every beat carries data, and tlast only on the final byte
  assign beat_bad = !byte_keep_i || (byte_last_i != (idx_q == 4'(CMD_BYTES - 1)));

  // Final byte accepted cleanly
  assign cmd_ok = accept && !beat_bad && (state_q == PS_IDOP);

  // Hold off while a command is out, busy, failed or being cleared
  assign byte_ready_o = !clear_i && !cmd_vld_o &&
                        (state_q inside {PS_MAGIC, PS_ADDR, PS_WORD, PS_IDOP});

  assign cmd_bad_o = (state_q == PS_FAIL);

  // Parse FSM, byte index tracks position within the frame
  always_ff @(posedge clock) begin
    if (!rst_n_i || clear_i) begin
      state_q <= PS_MAGIC;
      idx_q   <= '0;
    end else if (accept && beat_bad) begin
      state_q <= PS_FAIL;
    end else if (accept) begin
      idx_q <= idx_q + 4'd1;
      case (state_q)
        PS_MAGIC: begin
          if (idx_q == 4'(MAGIC_LAST)) begin
            state_q <= (word_next == MMIO_MAGIC) ? PS_ADDR : PS_FAIL;
          end
        end
        PS_ADDR: begin
          if (idx_q == 4'(ADDR_LAST)) begin
            state_q <= PS_WORD;
          end
        end
        PS_WORD: begin
          if (idx_q == 4'(WORD_LAST)) begin
            state_q <= PS_IDOP;
          end
        end
        PS_IDOP: begin
          // Whole frame in, wait for the endpoint to finish with it
          state_q <= PS_BUSY;
          idx_q   <= '0;
        end
        default: begin
          state_q <= state_q;
        end
      endcase
    end else if (state_q == PS_BUSY && restart_i) begin
      state_q <= PS_MAGIC;
    end
  end

  // Field capture, each field taken as its last byte arrives
  always_ff @(posedge clock) begin
    if (accept) begin
      word_q <= word_next;
      if (state_q == PS_ADDR && idx_q == 4'(ADDR_LAST)) begin
        // LUN rides in the top nibble of the address word
        {cmd_lun_o, cmd_adr_o} <= word_next;
      end
      if (state_q == PS_WORD && idx_q == 4'(WORD_LAST)) begin
        cmd_len_o <= word_next[31:16];
      end
      if (state_q == PS_IDOP) begin
        cmd_tag_o <= byte_data_i[7:4];
        cmd_dir_o <= byte_data_i[DIR_BIT];
        cmd_apb_o <= byte_data_i[APB_BIT];
        cmd_op_o  <= mmio_op_e'(byte_data_i[1:0]);
      end
    end
  end

  // Command valid and completion pulse
  always_ff @(posedge clock) begin
    if (!rst_n_i || clear_i) begin
      cmd_vld_o  <= 1'b0;
      cmd_done_o <= 1'b0;
    end else begin
      cmd_done_o <= cmd_ok;
      if (cmd_ok) begin
        cmd_vld_o <= 1'b1;
      end else if (cmd_vld_o && cmd_ready_i) begin
        cmd_vld_o <= 1'b0;
      end
    end
  end

endmodule

// ==== design/packet_fifo.sv ====
module packet_fifo #(
  parameter int  FIFO_DEPTH = usb_ep_pkg::DEF_FIFO_DEPTH,
  localparam int AW         = $clog2(FIFO_DEPTH)
) (
  input  logic        clock,
  input  logic        rst_n_i,
  input  logic        flush_i,
  input  logic        s_valid_i,
  output logic        s_ready_o,
  input  logic        s_keep_i,
  input  logic        s_last_i,
  input  logic [7:0]  s_data_i,
  input  logic        commit_i,
  input  logic        drop_i,
  output logic        m_valid_o,
  input  logic        m_ready_i,
  output logic        m_last_o,
  output logic [7:0]  m_data_o,
  output logic [AW:0] level_o
);

  localparam int LVL_W = AW + 1;

  // Payload and per-byte end-of-frame flag
  logic [7:0]       dat_mem [FIFO_DEPTH];
  logic             lst_mem [FIFO_DEPTH];

  // Pointers carry one extra bit to tell full from empty
  logic [AW:0]      wr_q;
  logic [AW:0]      cm_q;
  logic [AW:0]      rd_q;
  logic [AW:0]      used;
  logic [AW-1:0]    wr_prev;
  logic             push;
  logic             mark;
  logic             load;

  assign used    = wr_q - rd_q;
  assign wr_prev = wr_q[AW-1:0] - 1'b1;

  assign s_ready_o = (used != LVL_W'(FIFO_DEPTH));

  // Only bytes with keep set are stored
  assign push = s_valid_i && s_ready_o && s_keep_i;

  // Empty last beat after data, so flag the byte before it instead
  assign mark = s_valid_i && s_ready_o && !s_keep_i && s_last_i && (wr_q != cm_q);

  // Output register refills from committed bytes only
  assign load = (rd_q != cm_q) && (!m_valid_o || m_ready_i);

  // Free space, including the pending frame as used
  assign level_o = LVL_W'(FIFO_DEPTH) - used;

  always_ff @(posedge clock) begin
    if (push) begin
      dat_mem[wr_q[AW-1:0]] <= s_data_i;
      lst_mem[wr_q[AW-1:0]] <= s_last_i;
    end else if (mark) begin
      lst_mem[wr_prev] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n_i || flush_i) begin
      wr_q      <= '0;
      cm_q      <= '0;
      rd_q      <= '0;
      m_valid_o <= 1'b0;
    end else begin
      // Bad frame rewinds to the last commit point
      if (drop_i) begin
        wr_q <= cm_q;
      end else if (push) begin
        wr_q <= wr_q + 1'b1;
      end
      // ACK sent, frame becomes visible downstream
      if (commit_i && !drop_i) begin
        cm_q <= wr_q;
      end
      if (load) begin
        rd_q      <= rd_q + 1'b1;
        m_valid_o <= 1'b1;
      end else if (m_ready_i) begin
        m_valid_o <= 1'b0;
      end
    end
  end

  // Registered read port
  always_ff @(posedge clock) begin
    if (load) begin
      m_data_o <= dat_mem[rd_q[AW-1:0]];
      m_last_o <= lst_mem[rd_q[AW-1:0]];
    end
  end

endmodule

// ==== design/ep_control.sv ====
module ep_control #(
  parameter int  MAX_PACKET_LENGTH = usb_ep_pkg::DEF_MAX_PACKET,
  localparam int CNT_W             = $clog2(MAX_PACKET_LENGTH + 1)
) (
  input  logic                   clock,
  input  logic                   rst_n_i,
  input  logic                   set_conf_i,
  input  logic                   clr_conf_i,
  input  logic [CNT_W-1:0]       max_size_i,
  input  logic                   selected_i,
  input  logic                   ack_sent_i,
  input  logic                   acc_valid_i,
  input  logic                   acc_keep_i,
  input  logic                   acc_last_i,
  input  logic                   cmd_done_i,
  input  mmio_cmd_pkg::mmio_op_e cmd_op_i,
  input  logic                   cmd_bad_i,
  input  logic [31:0]            fifo_level_i,
  input  logic                   mmio_sent_i,
  input  logic                   mmio_resp_i,
  output logic                   clear_o,
  output logic                   restart_o,
  output logic                   xfer_o,
  output logic                   ep_ready_o,
  output logic                   stalled_o,
  output logic                   parity_o,
  output logic                   mmio_recv_o
);
  import mmio_cmd_pkg::*;
  import usb_ep_pkg::*;

  ep_state_e        state_q;
  mmio_op_e         op_q;
  logic             enable_q;
  logic             stall_q;
  logic             clear_q;
  logic             ready_q;
  logic             parity_q;
  logic             recv_q;
  logic             restart_q;
  logic             xfer_q;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W:0]   count_next;
  logic             conf_evt;
  logic             frame_end;
  logic             phase_end;
  logic             space_ok;

  assign conf_evt   = set_conf_i || clr_conf_i;
  assign count_next = {1'b0, count_q} + {{CNT_W{1'b0}}, acc_keep_i};
  assign frame_end  = acc_valid_i && acc_last_i;
  // Short frame or ZDP closes the data phase
  assign phase_end  = frame_end && (count_next < {1'b0, max_size_i});
  // Room for at least one full packet
  assign space_ok   = (fifo_level_i >= 32'(max_size_i));

  assign clear_o     = clear_q;
  assign restart_o   = restart_q;
  assign xfer_o      = xfer_q;
  assign ep_ready_o  = ready_q;
  assign stalled_o   = stall_q;
  assign parity_o    = parity_q;
  assign mmio_recv_o = recv_q;

  // Enable, stall, ready and data toggle
  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      enable_q <= 1'b0;
      stall_q  <= 1'b0;
      clear_q  <= 1'b1;
      ready_q  <= 1'b0;
      parity_q <= 1'b0;
    end else begin
      // Hold everything cleared while disabled and on any config change
      clear_q <= conf_evt || !enable_q;
      if (clr_conf_i) begin
        enable_q <= 1'b0;
      end else if (set_conf_i) begin
        enable_q <= 1'b1;
      end else if (stall_q) begin
        enable_q <= 1'b0;
      end
      // Parser fail level is stale while clear is in flight
      if (conf_evt) begin
        stall_q <= 1'b0;
      end else if (cmd_bad_i && !clear_q) begin
        stall_q <= 1'b1;
      end
      ready_q <= enable_q && !stall_q && space_ok;
      if (conf_evt) begin
        parity_q <= 1'b0;
      end else if (selected_i && ack_sent_i) begin
        parity_q <= !parity_q;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (cmd_done_i) begin
      op_q <= cmd_op_i;
    end
  end

  // Endpoint FSM, data phase steering and frame byte count
  always_ff @(posedge clock) begin
    if (!rst_n_i || clear_q) begin
      state_q   <= EP_IDLE;
      xfer_q    <= 1'b0;
      recv_q    <= 1'b0;
      restart_q <= 1'b0;
      count_q   <= '0;
    end else begin
      recv_q    <= xfer_q && phase_end;
      restart_q <= (state_q == EP_RESP) && mmio_resp_i;
      if (frame_end) begin
        count_q <= '0;
      end else if (acc_valid_i && acc_keep_i) begin
        count_q <= count_next[CNT_W-1:0];
      end
      if (stall_q) begin
        state_q <= EP_HALT;
        xfer_q  <= 1'b0;
      end else begin
        case (state_q)
          EP_IDLE: begin
            if (cmd_done_i) begin
              state_q <= EP_XFER;
              xfer_q  <= (cmd_op_i == OP_STORE);
            end
          end
          EP_XFER: begin
            if (phase_end) begin
              xfer_q <= 1'b0;
            end
            // STORE finishes on the data phase, others on the back end
            if ((op_q == OP_STORE) ? recv_q : mmio_sent_i) begin
              state_q <= EP_RESP;
            end
          end
          EP_RESP: begin
            if (mmio_resp_i) begin
              state_q <= EP_IDLE;
            end
          end
          default: begin
            state_q <= state_q;
          end
        endcase
      end
    end
  end

endmodule

// ==== design/mmio_ep_out.sv ====
module mmio_ep_out #(
  parameter int  MAX_PACKET_LENGTH = usb_ep_pkg::DEF_MAX_PACKET,
  parameter int  FIFO_DEPTH        = usb_ep_pkg::DEF_FIFO_DEPTH,
  localparam int CNT_W             = $clog2(MAX_PACKET_LENGTH + 1),
  localparam int LVL_W             = $clog2(FIFO_DEPTH) + 1
) (
  input  logic                           clock,
  input  logic                           rst_n_i,
  input  logic                           set_conf_i,
  input  logic                           clr_conf_i,
  input  logic [CNT_W-1:0]               max_size_i,
  input  logic                           selected_i,
  input  logic                           rx_error_i,
  input  logic                           ack_sent_i,
  output logic                           ep_ready_o,
  output logic                           stalled_o,
  output logic                           parity_o,
  output logic                           mmio_recv_o,
  input  logic                           mmio_sent_i,
  input  logic                           mmio_resp_i,
  input  logic                           usb_tvalid_i,
  output logic                           usb_tready_o,
  input  logic                           usb_tkeep_i,
  input  logic                           usb_tlast_i,
  input  logic [7:0]                     usb_tdata_i,
  output logic                           cmd_vld_o,
  input  logic                           cmd_ready_i,
  output mmio_cmd_pkg::mmio_op_e         cmd_op_o,
  output logic                           cmd_dir_o,
  output logic                           cmd_apb_o,
  output logic [mmio_cmd_pkg::TAG_W-1:0] cmd_tag_o,
  output logic [mmio_cmd_pkg::LEN_W-1:0] cmd_len_o,
  output logic [mmio_cmd_pkg::LUN_W-1:0] cmd_lun_o,
  output logic [mmio_cmd_pkg::ADR_W-1:0] cmd_adr_o,
  output logic                           dat_tvalid_o,
  input  logic                           dat_tready_i,
  output logic                           dat_tlast_o,
  output logic [7:0]                     dat_tdata_o
);

  logic             xfer;
  logic             clear;
  logic             restart;
  logic             par_ready;
  logic             fifo_ready;
  logic             cmd_done;
  logic             cmd_bad;
  logic [LVL_W-1:0] fifo_level;

  // Data phase goes to the FIFO, everything else to the parser
  assign usb_tready_o = xfer ? fifo_ready : par_ready;

  mmio_cmd_parser i_parser (
    .clock        (clock),
    .rst_n_i      (rst_n_i),
    .clear_i      (clear),
    .restart_i    (restart),
    .byte_valid_i (usb_tvalid_i && !xfer),
    .byte_ready_o (par_ready),
    .byte_keep_i  (usb_tkeep_i),
    .byte_last_i  (usb_tlast_i),
    .byte_data_i  (usb_tdata_i),
    .cmd_vld_o    (cmd_vld_o),
    .cmd_ready_i  (cmd_ready_i),
    .cmd_op_o     (cmd_op_o),
    .cmd_dir_o    (cmd_dir_o),
    .cmd_apb_o    (cmd_apb_o),
    .cmd_tag_o    (cmd_tag_o),
    .cmd_len_o    (cmd_len_o),
    .cmd_lun_o    (cmd_lun_o),
    .cmd_adr_o    (cmd_adr_o),
    .cmd_done_o   (cmd_done),
    .cmd_bad_o    (cmd_bad)
  );

  packet_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_packet_fifo (
    .clock     (clock),
    .rst_n_i   (rst_n_i),
    .flush_i   (clear),
    .s_valid_i (usb_tvalid_i && xfer),
    .s_ready_o (fifo_ready),
    .s_keep_i  (usb_tkeep_i),
    .s_last_i  (usb_tlast_i),
    .s_data_i  (usb_tdata_i),
    .commit_i  (ack_sent_i),
    .drop_i    (rx_error_i),
    .m_valid_o (dat_tvalid_o),
    .m_ready_i (dat_tready_i),
    .m_last_o  (dat_tlast_o),
    .m_data_o  (dat_tdata_o),
    .level_o   (fifo_level)
  );

  ep_control #(
    .MAX_PACKET_LENGTH (MAX_PACKET_LENGTH)
  ) i_ep_control (
    .clock        (clock),
    .rst_n_i      (rst_n_i),
    .set_conf_i   (set_conf_i),
    .clr_conf_i   (clr_conf_i),
    .max_size_i   (max_size_i),
    .selected_i   (selected_i),
    .ack_sent_i   (ack_sent_i),
    // Beat taken by the FIFO during the data phase
    .acc_valid_i  (usb_tvalid_i && xfer && fifo_ready),
    .acc_keep_i   (usb_tkeep_i),
    .acc_last_i   (usb_tlast_i),
    .cmd_done_i   (cmd_done),
    .cmd_op_i     (cmd_op_o),
    .cmd_bad_i    (cmd_bad),
    .fifo_level_i (32'(fifo_level)),
    .mmio_sent_i  (mmio_sent_i),
    .mmio_resp_i  (mmio_resp_i),
    .clear_o      (clear),
    .restart_o    (restart),
    .xfer_o       (xfer),
    .ep_ready_o   (ep_ready_o),
    .stalled_o    (stalled_o),
    .parity_o     (parity_o),
    .mmio_recv_o  (mmio_recv_o)
  );

endmodule

// ==== bench/tb_mmio_ep_out.sv ====
module tb_mmio_ep_out;
  timeunit 1ns;
  timeprecision 100ps;

  import mmio_cmd_pkg::*;

  localparam int          CLK_PERIOD = 40;
  localparam int          MAX_PKT    = 16;
  localparam int          CNT_W      = $clog2(MAX_PKT + 1);
  localparam int          WAIT_LIMIT = 200;
  localparam logic [31:0] LFSR_SEED  = 32'hd435;
  localparam logic [31:0] LFSR_POLY  = 32'h8020_0003;

  // Watchdog budget, tests x frames x bytes x period x margin
  localparam int NUM_TESTS       = 12;
  localparam int FRAMES_PER_TEST = 4;
  localparam int BYTES_PER_FRAME = 16;
  localparam int MARGIN          = 4;
  localparam int WATCHDOG_NS     =
    NUM_TESTS * FRAMES_PER_TEST * BYTES_PER_FRAME * CLK_PERIOD * MARGIN;

  // Expected command fields
  typedef struct packed {
    logic [1:0]       op;
    logic             dir;
    logic             apb;
    logic [TAG_W-1:0] tag;
    logic [LEN_W-1:0] len;
    logic [LUN_W-1:0] lun;
    logic [ADR_W-1:0] adr;
  } cmd_t;

  logic             clock = 1'b0;
  logic             rst_n_i;
  logic             set_conf_i;
  logic             clr_conf_i;
  logic [CNT_W-1:0] max_size_i;
  logic             selected_i;
  logic             rx_error_i;
  logic             ack_sent_i;
  logic             ep_ready_o;
  logic             stalled_o;
  logic             parity_o;
  logic             mmio_recv_o;
  logic             mmio_sent_i;
  logic             mmio_resp_i;
  logic             usb_tvalid_i;
  logic             usb_tready_o;
  logic             usb_tkeep_i;
  logic             usb_tlast_i;
  logic [7:0]       usb_tdata_i;
  logic             cmd_vld_o;
  logic             cmd_ready_i;
  mmio_op_e         cmd_op_o;
  logic             cmd_dir_o;
  logic             cmd_apb_o;
  logic [TAG_W-1:0] cmd_tag_o;
  logic [LEN_W-1:0] cmd_len_o;
  logic [LUN_W-1:0] cmd_lun_o;
  logic [ADR_W-1:0] cmd_adr_o;
  logic             dat_tvalid_o;
  logic             dat_tready_i;
  logic             dat_tlast_o;
  logic [7:0]       dat_tdata_o;

  logic [31:0]      lfsr_q = LFSR_SEED;
  logic             throttle = 1'b0;
  logic             exp_parity;
  int               recv_count = 0;
  // Expected output beats, {last, data}
  logic [8:0]       exp_q [$];
  logic [8:0]       cmp_beat;
  logic [7:0]       pkt [2*MAX_PKT];

  mmio_ep_out #(
    .MAX_PACKET_LENGTH (MAX_PKT)
  ) i_mmio_ep_out (.*);

  always #(CLK_PERIOD / 2) clock = !clock;

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_with_error($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // Galois step, output bit is the one shifted out
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_POLY) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      r      = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return r;
  endfunction

  // Byte i of the frame sits in bits 8i+7..8i
  function automatic logic [87:0] make_cmd(input logic [1:0] op);
    logic [87:0] f;
    f[7:0]   = 8'h54;
    f[15:8]  = 8'h41;
    f[23:16] = 8'h52;
    f[31:24] = 8'h54;
    f[63:32] = take_bits(32);
    f[79:64] = 16'(take_bits(16));
    f[87:82] = 6'(take_bits(6));
    f[81:80] = op;
    return f;
  endfunction

  function automatic cmd_t decode_cmd(input logic [87:0] f);
    cmd_t c;
    // Address word is bytes 4..7, LUN in its top nibble
    c.lun = f[63:60];
    c.adr = f[59:32];
    c.len = f[79:64];
    // Tag, dir, apb and op all in byte 10
    c.tag = f[87:84];
    c.dir = f[83];
    c.apb = f[82];
    c.op  = f[81:80];
    return c;
  endfunction

  function automatic logic [1:0] random_op();
    logic [1:0] op;
    op = 2'(take_bits(2));
    // STORE gets its own tests
    while (op == 2'(OP_STORE)) begin
      op = 2'(take_bits(2));
    end
    return op;
  endfunction

  function automatic logic probe(input string name);
    case (name)
      "cmd_vld_o":  return cmd_vld_o;
      "stalled_o":  return stalled_o;
      "ep_ready_o": return ep_ready_o;
      default:      return 1'bx;
    endcase
  endfunction

  task automatic wait_level(input string name, input logic level);
    int cycles;
    cycles = 0;
    while (probe(name) !== level) begin
      @(negedge clock);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        stop_with_error($sformatf("Timed out waiting for %s to become %0b", name, level));
      end
    end
  endtask

  // Ready depends on registers only, so it is settled at the falling edge
  task automatic send_beat(input logic [7:0] data, input logic keep, input logic last);
    int cycles;
    cycles       = 0;
    usb_tvalid_i = 1'b1;
    usb_tdata_i  = data;
    usb_tkeep_i  = keep;
    usb_tlast_i  = last;
    while (!usb_tready_o) begin
      @(negedge clock);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        stop_with_error("USB stream ready stayed low while a beat was waiting");
      end
    end
    @(negedge clock);
  endtask

  task automatic end_stream();
    usb_tvalid_i = 1'b0;
    usb_tlast_i  = 1'b0;
    usb_tkeep_i  = 1'b1;
  endtask

  task automatic send_bytes(input logic [87:0] f, input int count, input logic last);
    int i;
    for (i = 0; i < count; i++) begin
      send_beat(f[8*i +: 8], 1'b1, last && (i == count - 1));
    end
    end_stream();
  endtask

  task automatic fill_packet(input int first, input int len);
    int i;
    for (i = first; i < first + len; i++) begin
      pkt[i] = 8'(take_bits(8));
    end
  endtask

  task automatic send_packet(input int first, input int len);
    int i;
    for (i = 0; i < len; i++) begin
      send_beat(pkt[first+i], 1'b1, i == len - 1);
    end
    end_stream();
  endtask

  task automatic expect_packet(input int first, input int len);
    int i;
    for (i = 0; i < len; i++) begin
      exp_q.push_back({i == len - 1, pkt[first+i]});
    end
  endtask

  // Data toggle flips only on an ACK to this endpoint
  task automatic ack_pulse(input logic sel, input logic ack);
    selected_i = sel;
    ack_sent_i = ack;
    @(negedge clock);
    selected_i = 1'b0;
    ack_sent_i = 1'b0;
    if (sel && ack) begin
      exp_parity = !exp_parity;
    end
    check_value("parity_o", 32'(parity_o), 32'(exp_parity));
  endtask

  task automatic check_fields(input cmd_t e);
    check_value("cmd_vld_o", 32'(cmd_vld_o), 32'd1);
    check_value("cmd_op_o", 32'(cmd_op_o), 32'(e.op));
    check_value("cmd_dir_o", 32'(cmd_dir_o), 32'(e.dir));
    check_value("cmd_apb_o", 32'(cmd_apb_o), 32'(e.apb));
    check_value("cmd_tag_o", 32'(cmd_tag_o), 32'(e.tag));
    check_value("cmd_len_o", 32'(cmd_len_o), 32'(e.len));
    check_value("cmd_lun_o", 32'(cmd_lun_o), 32'(e.lun));
    check_value("cmd_adr_o", 32'(cmd_adr_o), 32'(e.adr));
  endtask

  // Hold ready low a random while, valid and fields must not move
  task automatic take_cmd(input logic [87:0] f);
    cmd_t e;
    int   hold;
    e    = decode_cmd(f);
    hold = int'(take_bits(3));
    wait_level("cmd_vld_o", 1'b1);
    repeat (hold + 1) begin
      check_fields(e);
      @(negedge clock);
    end
    cmd_ready_i = 1'b1;
    check_fields(e);
    @(negedge clock);
    cmd_ready_i = 1'b0;
    check_value("cmd_vld_o", 32'(cmd_vld_o), 32'd0);
  endtask

  task automatic finish_cmd();
    mmio_sent_i = 1'b1;
    @(negedge clock);
    mmio_sent_i = 1'b0;
    mmio_resp_i = 1'b1;
    @(negedge clock);
    mmio_resp_i = 1'b0;
  endtask

  task automatic run_cmd(input logic [1:0] op);
    logic [87:0] f;
    f = make_cmd(op);
    send_bytes(f, CMD_BYTES, 1'b1);
    take_cmd(f);
    finish_cmd();
  endtask

  task automatic configure();
    set_conf_i = 1'b1;
    @(negedge clock);
    set_conf_i = 1'b0;
    // Set configuration restarts the data toggle
    exp_parity = 1'b0;
    wait_level("ep_ready_o", 1'b1);
    check_value("stalled_o", 32'(stalled_o), 32'd0);
    check_value("parity_o", 32'(parity_o), 32'd0);
  endtask

  task automatic expect_stall();
    wait_level("stalled_o", 1'b1);
    wait_level("ep_ready_o", 1'b0);
  endtask

  // Switched on a rising edge so no falling-edge draw races with it
  task automatic set_throttle(input logic on);
    @(posedge clock);
    throttle = on;
    @(negedge clock);
  endtask

  task automatic wait_recv(input int target);
    int cycles;
    cycles = 0;
    while (recv_count < target) begin
      @(negedge clock);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        stop_with_error("mmio_recv_o did not pulse at the end of the data phase");
      end
    end
    repeat (3) @(negedge clock);
    check_value("mmio_recv_o pulses", 32'(recv_count), 32'(target));
  endtask

  task automatic drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0) begin
      @(negedge clock);
      cycles++;
      if (cycles > 4 * WAIT_LIMIT) begin
        stop_with_error("Committed data never left the FIFO");
      end
    end
  endtask

  task automatic finish_store();
    mmio_resp_i = 1'b1;
    @(negedge clock);
    mmio_resp_i = 1'b0;
  endtask

  // One full frame, one short frame, output throttled
  task automatic store_short_test();
    logic [87:0] f;
    int          base;
    int          len;
    f = make_cmd(2'(OP_STORE));
    send_bytes(f, CMD_BYTES, 1'b1);
    take_cmd(f);
    base = recv_count;
    len  = 1 + int'(take_bits(4) % (MAX_PKT - 1));
    fill_packet(0, MAX_PKT);
    fill_packet(MAX_PKT, len);
    set_throttle(1'b1);
    send_packet(0, MAX_PKT);
    expect_packet(0, MAX_PKT);
    ack_pulse(1'b1, 1'b1);
    send_packet(MAX_PKT, len);
    wait_recv(base + 1);
    expect_packet(MAX_PKT, len);
    ack_pulse(1'b1, 1'b1);
    drain();
    set_throttle(1'b0);
    finish_store();
  endtask

  // Errored frame is dropped, its resend lands, ZDP closes the phase
  task automatic store_retry_test();
    logic [87:0] f;
    int          base;
    f = make_cmd(2'(OP_STORE));
    send_bytes(f, CMD_BYTES, 1'b1);
    take_cmd(f);
    base = recv_count;
    fill_packet(0, MAX_PKT);
    send_packet(0, MAX_PKT);
    rx_error_i = 1'b1;
    @(negedge clock);
    rx_error_i = 1'b0;
    send_packet(0, MAX_PKT);
    expect_packet(0, MAX_PKT);
    ack_pulse(1'b1, 1'b1);
    send_beat(8'h00, 1'b0, 1'b1);
    end_stream();
    wait_recv(base + 1);
    ack_pulse(1'b1, 1'b1);
    drain();
    finish_store();
  endtask

  always @(negedge clock) begin
    if (throttle) begin
      dat_tready_i = 1'(take_bits(1));
    end else begin
      dat_tready_i = 1'b1;
    end
  end

  // Compare every output handshake against the expected queue
  always @(posedge clock) begin
    if (rst_n_i && dat_tvalid_o && dat_tready_i) begin
      if (exp_q.size() == 0) begin
        stop_with_error("Data beat left the FIFO when none was expected");
      end else begin
        cmp_beat = exp_q.pop_front();
        check_value("dat_tdata_o", 32'(dat_tdata_o), 32'(cmp_beat[7:0]));
        check_value("dat_tlast_o", 32'(dat_tlast_o), 32'(cmp_beat[8]));
      end
    end
  end

  always @(posedge clock) begin
    if (mmio_recv_o) begin
      recv_count <= recv_count + 1;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    stop_with_error("Watchdog expired before the tests finished");
  end

  initial begin
    logic [87:0] f;
    int          k;
    rst_n_i      = 1'b0;
    set_conf_i   = 1'b0;
    clr_conf_i   = 1'b0;
    max_size_i   = CNT_W'(MAX_PKT);
    selected_i   = 1'b0;
    rx_error_i   = 1'b0;
    ack_sent_i   = 1'b0;
    mmio_sent_i  = 1'b0;
    mmio_resp_i  = 1'b0;
    usb_tvalid_i = 1'b0;
    usb_tkeep_i  = 1'b1;
    usb_tlast_i  = 1'b0;
    usb_tdata_i  = 8'h00;
    cmd_ready_i  = 1'b0;
    dat_tready_i = 1'b0;
    exp_parity   = 1'b0;
    repeat (10) @(negedge clock);
    rst_n_i = 1'b1;
    @(negedge clock);
    check_value("cmd_vld_o", 32'(cmd_vld_o), 32'd0);
    check_value("dat_tvalid_o", 32'(dat_tvalid_o), 32'd0);
    check_value("usb_tready_o", 32'(usb_tready_o), 32'd0);
    check_value("stalled_o", 32'(stalled_o), 32'd0);
    check_value("ep_ready_o", 32'(ep_ready_o), 32'd0);
    check_value("parity_o", 32'(parity_o), 32'd0);
    check_value("mmio_recv_o", 32'(mmio_recv_o), 32'd0);
    configure();

    // Random non-STORE commands
    repeat (6) run_cmd(random_op());

    // Bad magic byte, stall, then recover
    f = make_cmd(random_op());
    k = int'(take_bits(2));
    f[8*k +: 8] = f[8*k +: 8] ^ 8'h01;
    send_bytes(f, 4, 1'b0);
    expect_stall();
    configure();
    run_cmd(random_op());

    // tlast well before byte 11
    f = make_cmd(random_op());
    k = 5 + int'(take_bits(2));
    send_bytes(f, k, 1'b1);
    expect_stall();
    configure();
    run_cmd(random_op());

    store_short_test();
    store_retry_test();

    // Data toggle against random ACK and select patterns
    repeat (12) ack_pulse(1'(take_bits(1)), 1'(take_bits(1)));

    // Odd toggle going in, set configuration must bring it back to zero
    if (!exp_parity) begin
      ack_pulse(1'b1, 1'b1);
    end
    configure();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== all.f ====
design/mmio_cmd_pkg.sv
design/usb_ep_pkg.sv
design/mmio_cmd_parser.sv
design/packet_fifo.sv
design/ep_control.sv
design/mmio_ep_out.sv
bench/tb_mmio_ep_out.sv

// ==== Bender.yml ====
package:
  name: mmio_ep_out

sources:
  - design/mmio_cmd_pkg.sv
  - design/usb_ep_pkg.sv
  - design/mmio_cmd_parser.sv
  - design/packet_fifo.sv
  - design/ep_control.sv
  - design/mmio_ep_out.sv
  - target: test
    files:
      - bench/tb_mmio_ep_out.sv
